/* colour_classifier.sv */
`default_nettype none

module colour_classifier #(
	parameter int run_len     = 3,
	parameter int horizon_row = 182
) (
	input  logic                     clk,
	input  logic                     reset_n,
	input  imgproc_pkg::hsv_t        hsv,
	input  imgproc_pkg::rgb_t        pix,
	input  imgproc_pkg::coord_t      y,
	input  logic                     advance,
	input  logic                     clear,
	output imgproc_pkg::class_vec_t  grouped,
	output imgproc_pkg::rgb_t        high_pix
);
	import imgproc_pkg::*;

	class_vec_t match;
	logic [NUM_CLASSES-1:0][run_len-2:0] hist;   // Previous matches, newest in bit 0
	class_e hit;
	logic [7:0] grey;

	// Window test per class, only below the horizon
	always_comb begin
		for (int i = 0; i < NUM_CLASSES; i++) begin
			match[i] = (hsv.hue >= THRESH[i].hue_lo) && (hsv.hue <= THRESH[i].hue_hi) &&
				(hsv.sat >= THRESH[i].sat_lo) && (hsv.sat <= THRESH[i].sat_hi) &&
				(hsv.val >= THRESH[i].val_lo) && (hsv.val <= THRESH[i].val_hi) &&
				(y >= coord_t'(horizon_row));
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n || clear) begin
			hist <= '0;   // Runs never span frames
		end else if (advance) begin
			for (int i = 0; i < NUM_CLASSES; i++)
				hist[i] <= (hist[i] << 1) | match[i];
		end
	end

	// Run of run_len pixels ending at this one
	always_comb begin
		for (int i = 0; i < NUM_CLASSES; i++)
			grouped[i] = match[i] & (&hist[i]);
	end

	always_comb begin
		if (match[0])
			hit = CLASS_RED;
		else if (match[1])
			hit = CLASS_YELLOW;
		else if (match[2])
			hit = CLASS_BLUE;
		else
			hit = CLASS_NONE;
	end

	assign grey = pix.g[7:1] + pix.r[7:2] + pix.b[7:2];   // Luma estimate

	assign high_pix = (hit == CLASS_NONE) ? {grey, grey, grey} : CLASS_COLOUR[int'(hit) - 1];

endmodule

`default_nettype wire

/* eee_imgproc.sv */
`default_nettype none

module eee_imgproc #(
	parameter int image_w      = 640,
	parameter int image_h      = 480,
	parameter int horizon_row  = 182,
	parameter int run_len      = 3,
	parameter int msg_interval = 6,
	parameter int fifo_depth   = 256
) (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    s_chipselect,
	input  logic                    s_read,
	input  logic                    s_write,
	output imgproc_pkg::msg_word_t  s_readdata,
	input  imgproc_pkg::msg_word_t  s_writedata,
	input  logic [2:0]              s_address,
	input  imgproc_pkg::rgb_t       sink_data,
	input  logic                    sink_valid,
	output logic                    sink_ready,
	input  logic                    sink_sop,
	input  logic                    sink_eop,
	output imgproc_pkg::rgb_t       source_data,
	output logic                    source_valid,
	input  logic                    source_ready,
	output logic                    source_sop,
	output logic                    source_eop,
	input  logic                    mode
);
	import imgproc_pkg::*;

	beat_t sink_beat, in_beat, out_beat, source_beat;
	logic in_valid, out_ready, in_fire;
	hsv_t hsv;
	coord_t y;
	logic is_video, frame_end;
	box_set_t boxes;
	class_vec_t grouped, edge_hit;
	rgb_t high_pix, mark_pix;
	msg_word_t wr_data, fifo_data;
	logic wr_en, fifo_rd, flush, fifo_empty;
	fill_t fifo_count;

	assign sink_beat = '{pix: sink_data, sop: sink_sop, eop: sink_eop};
	assign in_fire   = in_valid & out_ready;   // Whole pixel path steps on this

	stream_reg in_reg (.clk, .reset_n, .in_valid(sink_valid), .in_ready(sink_ready),
		.in_beat(sink_beat), .out_valid(in_valid), .out_ready, .out_beat(in_beat));

	hsv_convert u_hsv (.pix(in_beat.pix), .hsv);

	colour_classifier #(.run_len(run_len), .horizon_row(horizon_row)) u_classify (
		.clk, .reset_n, .hsv, .pix(in_beat.pix), .y,
		.advance(in_fire & ~in_beat.sop & is_video), .clear(in_fire & in_beat.eop),
		.grouped, .high_pix);

	frame_tracker #(.image_w(image_w), .image_h(image_h)) u_tracker (
		.clk, .reset_n, .beat(in_beat), .fire(in_fire), .grouped,
		.x(), .y, .is_video, .frame_end, .boxes, .edge_hit);

	//////////////////////////////////////////////////////////////////////
	// Box edges drawn over the highlight pixel
	always_comb begin
		mark_pix = high_pix;
		for (int i = NUM_CLASSES - 1; i >= 0; i--) begin
			if (edge_hit[i])
				mark_pix = CLASS_COLOUR[i];   // Lowest class wins
		end
		out_beat = in_beat;
		if (mode && !in_beat.sop && is_video)
			out_beat.pix = mark_pix;
	end

	stream_reg out_reg (.clk, .reset_n, .in_valid, .in_ready(out_ready),
		.in_beat(out_beat), .out_valid(source_valid), .out_ready(source_ready),
		.out_beat(source_beat));

	assign source_data = source_beat.pix;
	assign source_sop  = source_beat.sop;
	assign source_eop  = source_beat.eop;

	msg_writer #(.msg_interval(msg_interval), .fifo_depth(fifo_depth)) u_writer (
		.clk, .reset_n, .frame_end, .boxes, .fifo_count, .wr_en, .wr_data);

	msg_fifo #(.fifo_depth(fifo_depth)) u_fifo (.clk, .reset_n, .wr_en, .wr_data,
		.rd_en(fifo_rd), .flush, .rd_data(fifo_data), .count(fifo_count), .empty(fifo_empty));

	mm_regs u_regs (.clk, .reset_n, .chipselect(s_chipselect), .read(s_read),
		.write(s_write), .address(s_address), .writedata(s_writedata),
		.readdata(s_readdata), .fifo_data, .fifo_count, .fifo_empty, .fifo_rd, .flush);

endmodule

`default_nettype wire

/* frame_tracker.sv */
`default_nettype none

module frame_tracker #(
	parameter int image_w = 640,
	parameter int image_h = 480
) (
	input  logic                     clk,
	input  logic                     reset_n,
	input  imgproc_pkg::beat_t       beat,
	input  logic                     fire,
	input  imgproc_pkg::class_vec_t  grouped,
	output imgproc_pkg::coord_t      x,
	output imgproc_pkg::coord_t      y,
	output logic                     is_video,
	output logic                     frame_end,
	output imgproc_pkg::box_set_t    boxes,
	output imgproc_pkg::class_vec_t  edge_hit
);
	import imgproc_pkg::*;

	coord_t [NUM_CLASSES-1:0] x_min;
	coord_t [NUM_CLASSES-1:0] x_max;
	coord_t [NUM_CLASSES-1:0] min_nx;
	coord_t [NUM_CLASSES-1:0] max_nx;
	coord_t [NUM_CLASSES-1:0] left;   // Left edge column for the overlay
	logic pix_fire;

	assign pix_fire  = fire & ~beat.sop & is_video;
	assign frame_end = pix_fire & beat.eop;

	//////////////////////////////////////////////////////////////////////
	// Pixel coordinates and packet type
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x <= '0;
			y <= '0;
			is_video <= 1'b0;
		end else if (fire) begin
			if (beat.sop) begin
				x <= '0;
				y <= '0;
				is_video <= (beat.pix.b[3:0] == 4'h0);   // Packet type 0 is video
			end else if (x == coord_t'(image_w - 1)) begin
				x <= '0;
				y <= (y == coord_t'(image_h - 1)) ? '0 : y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Horizontal extent per class, including the current pixel
	always_comb begin
		for (int i = 0; i < NUM_CLASSES; i++) begin
			min_nx[i] = x_min[i];
			max_nx[i] = x_max[i];
			if (pix_fire && grouped[i]) begin
				if (x < x_min[i])
					min_nx[i] = x;
				if (x > x_max[i])
					max_nx[i] = x;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n || (fire && beat.sop)) begin
			for (int i = 0; i < NUM_CLASSES; i++) begin
				x_min[i] <= coord_t'(image_w - 1);
				x_max[i] <= '0;
			end
		end else begin
			x_min <= min_nx;
			x_max <= max_nx;
		end
	end

	// Latched at end of frame, drawn during the next one
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < NUM_CLASSES; i++) begin
				boxes.cls[i].right <= '1;   // Off screen until the first frame
				boxes.cls[i].width <= '0;
				left[i] <= '1;
			end
		end else if (frame_end) begin
			for (int i = 0; i < NUM_CLASSES; i++) begin
				boxes.cls[i].right <= max_nx[i];
				boxes.cls[i].width <= max_nx[i] - min_nx[i] + BOX_PAD;
				left[i] <= min_nx[i] - BOX_PAD;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_CLASSES; i++)
			edge_hit[i] = (x == left[i]) || (x == boxes.cls[i].right);
	end

endmodule

`default_nettype wire

/* hsv_convert.sv */
`default_nettype none

module hsv_convert (
	input  imgproc_pkg::rgb_t pix,
	output imgproc_pkg::hsv_t hsv
);
	import imgproc_pkg::*;

	always_comb begin
		int r;
		int g;
		int b;
		int mx;
		int mn;
		int d;
		int h;

		r = pix.r;
		g = pix.g;
		b = pix.b;

		mx = (r > g && r > b) ? r : (g > b) ? g : b;
		mn = (r < g && r < b) ? r : (g < b) ? g : b;
		d  = mx - mn;

		// Hue by 60 degree sector of the dominant channel
		if (d == 0)
			h = 0;   // Grey has no hue
		else if (mx == r)
			h = 60 * (g - b) / d;
		else if (mx == g)
			h = 120 + 60 * (b - r) / d;
		else
			h = 240 + 60 * (r - g) / d;

		if (h < 0)
			h = h + 360;   // Magenta side of red

		hsv.hue = hue_t'(h);
		hsv.sat = pct_t'((mx == 0) ? 0 : 100 * d / mx);
		hsv.val = pct_t'(100 * mx / 255);
	end

endmodule

`default_nettype wire

/* imgproc_golden.txt */
# F background mode rect_count action (0 read six words, 1 flush)
# R colour left right top bottom highlight, then M with six message words
F 808080 0 2 0
R a03214 2 6 3 5 ff0000
R c8be46 9 13 2 4 ffff00
M 00000052 00060007 00000059 000d0007 00000042 000007f6

# Yellow sits above the horizon and shows as grey
F 808080 1 3 1
R a03214 3 8 4 6 ff0000
R c8be46 1 4 0 1 a2a2a2
R 142864 10 14 5 7 0000ff
M 00000052 00080008 00000059 000007f6 00000042 000e0007

F 808080 1 2 0
R 142864 1 5 2 3 0000ff
R a03214 11 13 6 7 ff0000
M 00000052 000d0005 00000059 000007f6 00000042 00050007

F 20c040 0 1 0
R c8be46 4 10 3 7 ffff00
M 00000052 000007f6 00000059 000a0009 00000042 000007f6

F 20c040 1 3 0
R a03214 2 5 2 7 ff0000
R c8be46 7 9 4 5 ffff00
R 142864 11 14 2 4 0000ff
M 00000052 00050006 00000059 00090005 00000042 000e0006

/* imgproc_pkg.sv */
`default_nettype none

package imgproc_pkg;

	localparam int NUM_CLASSES = 3;

	typedef logic [10:0] coord_t;                  // Pixel column or row
	typedef logic [8:0]  hue_t;                    // Degrees, 0 to 359
	typedef logic [7:0]  pct_t;                    // Percent, 0 to 100
	typedef logic [NUM_CLASSES-1:0] class_vec_t;   // Bit 0 red, 1 yellow, 2 blue
	typedef logic [31:0] msg_word_t;
	typedef logic [8:0]  fill_t;                   // FIFO fill level, up to 256 words

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	typedef struct packed {
		rgb_t pix;
		logic sop;
		logic eop;
	} beat_t;

	typedef struct packed {
		hue_t hue;
		pct_t sat;
		pct_t val;
	} hsv_t;

	typedef struct packed {
		coord_t right;
		coord_t width;
	} box_t;

	typedef struct packed {
		box_t [NUM_CLASSES-1:0] cls;   // Indexed like class_vec_t
	} box_set_t;

	typedef enum logic [1:0] {CLASS_NONE, CLASS_RED, CLASS_YELLOW, CLASS_BLUE} class_e;

	typedef enum logic [2:0] {
		MSG_IDLE,
		MSG_ID_RED,
		MSG_BOX_RED,
		MSG_ID_YELLOW,
		MSG_BOX_YELLOW,
		MSG_ID_BLUE,
		MSG_BOX_BLUE
	} msg_state_e;

	//////////////////////////////////////////////////////////////////////
	// Box geometry and message IDs
	localparam coord_t BOX_PAD = 11'd5;   // Margin around the tracked run

	localparam msg_word_t ID_RED    = "R";
	localparam msg_word_t ID_YELLOW = "Y";
	localparam msg_word_t ID_BLUE   = "B";
	localparam msg_word_t BLOCK_ID  = 32'h1234EEE2;

	//////////////////////////////////////////////////////////////////////
	// Slave register map
	localparam logic [2:0] ADDR_STATUS = 3'd0;
	localparam logic [2:0] ADDR_MSG    = 3'd1;
	localparam logic [2:0] ADDR_ID     = 3'd2;
	localparam int FLUSH_BIT = 4;

	// HSV window per class
	typedef struct packed {
		hue_t hue_lo;
		hue_t hue_hi;
		pct_t sat_lo;
		pct_t sat_hi;
		pct_t val_lo;
		pct_t val_hi;
	} thresh_t;

	localparam thresh_t THRESH [NUM_CLASSES] = '{
		'{9'd6,   9'd24,  8'd69, 8'd94,  8'd39, 8'd73},   // Red
		'{9'd41,  9'd62,  8'd53, 8'd77,  8'd46, 8'd93},   // Yellow
		'{9'd199, 9'd240, 8'd35, 8'd100, 8'd16, 8'd47}    // Blue
	};

	localparam rgb_t CLASS_COLOUR [NUM_CLASSES] = '{24'hff0000, 24'hffff00, 24'h0000ff};

endpackage

`default_nettype wire

/* mm_regs.sv */
`default_nettype none

module mm_regs (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    chipselect,
	input  logic                    read,
	input  logic                    write,
	input  logic [2:0]              address,
	input  imgproc_pkg::msg_word_t  writedata,
	output imgproc_pkg::msg_word_t  readdata,
	input  imgproc_pkg::msg_word_t  fifo_data,
	input  imgproc_pkg::fill_t      fifo_count,
	input  logic                    fifo_empty,
	output logic                    fifo_rd,
	output logic                    flush
);
	import imgproc_pkg::*;

	logic rd_access;
	logic read_d;   // Read seen last cycle

	assign rd_access = chipselect & read;
	assign flush = chipselect & write & (address == ADDR_STATUS) & writedata[FLUSH_BIT];

	// One pop per read access, on its first cycle
	assign fifo_rd = rd_access & ~read_d & ~fifo_empty & (address == ADDR_MSG);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			readdata <= '0;
			read_d <= 1'b0;
		end else begin
			read_d <= rd_access;
			if (rd_access) begin
				case (address)
					ADDR_STATUS: readdata <= {16'b0, fifo_count[7:0], 8'b0};   // Flush reads as 0
					ADDR_MSG:    readdata <= fifo_data;
					ADDR_ID:     readdata <= BLOCK_ID;
					default:     readdata <= '0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* msg_fifo.sv */
`default_nettype none

module msg_fifo #(
	parameter int fifo_depth = 256
) (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    wr_en,
	input  imgproc_pkg::msg_word_t  wr_data,
	input  logic                    rd_en,
	input  logic                    flush,
	output imgproc_pkg::msg_word_t  rd_data,
	output imgproc_pkg::fill_t      count,
	output logic                    empty
);
	import imgproc_pkg::*;

	localparam int AW = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

	msg_word_t mem [fifo_depth];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	function automatic logic [AW-1:0] bump(input logic [AW-1:0] p);
		return (p == AW'(fifo_depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign empty   = (count == '0);
	assign do_wr   = wr_en && (count != fill_t'(fifo_depth));
	assign do_rd   = rd_en && !empty;
	assign rd_data = mem[rd_ptr];   // Head word, show-ahead

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (!reset_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= bump(wr_ptr);
			if (do_rd)
				rd_ptr <= bump(rd_ptr);
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	no_read_when_empty: assert property (@(posedge clk) disable iff (!reset_n)
		rd_en |-> !empty);

endmodule

`default_nettype wire

/* msg_writer.sv */
`default_nettype none

module msg_writer #(
	parameter int msg_interval = 6,
	parameter int fifo_depth   = 256
) (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    frame_end,
	input  imgproc_pkg::box_set_t   boxes,
	input  imgproc_pkg::fill_t      fifo_count,
	output logic                    wr_en,
	output imgproc_pkg::msg_word_t  wr_data
);
	import imgproc_pkg::*;

	localparam int CNT_W     = $clog2(msg_interval + 1);
	localparam int BURST_LEN = 2 * NUM_CLASSES;   // ID and box word per class

	msg_state_e state;
	msg_state_e state_nx;
	logic [CNT_W-1:0] frame_cnt;   // Frames left until the next burst
	logic room;

	function automatic msg_word_t box_word(input box_t b);
		return {5'b0, b.right, 5'b0, b.width};
	endfunction

	assign room  = (int'(fifo_count) + BURST_LEN) <= fifo_depth;
	assign wr_en = (state != MSG_IDLE);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= MSG_IDLE;
			frame_cnt <= '0;
		end else begin
			state <= state_nx;
			if (frame_end) begin
				if (frame_cnt == '0 && room && state == MSG_IDLE) begin
					state <= MSG_ID_RED;
					frame_cnt <= CNT_W'(msg_interval - 1);
				end else if (frame_cnt != '0) begin
					frame_cnt <= frame_cnt - 1'b1;   // Holds at zero while the FIFO is full
				end
			end
		end
	end

	always_comb begin
		state_nx = MSG_IDLE;
		wr_data = '0;
		case (state)
			MSG_ID_RED:     begin state_nx = MSG_BOX_RED;    wr_data = ID_RED; end
			MSG_BOX_RED:    begin state_nx = MSG_ID_YELLOW;  wr_data = box_word(boxes.cls[0]); end
			MSG_ID_YELLOW:  begin state_nx = MSG_BOX_YELLOW; wr_data = ID_YELLOW; end
			MSG_BOX_YELLOW: begin state_nx = MSG_ID_BLUE;    wr_data = box_word(boxes.cls[1]); end
			MSG_ID_BLUE:    begin state_nx = MSG_BOX_BLUE;   wr_data = ID_BLUE; end
			MSG_BOX_BLUE:   begin state_nx = MSG_IDLE;       wr_data = box_word(boxes.cls[2]); end
			default:        state_nx = MSG_IDLE;
		endcase
	end

	// Room check at burst start covers all six words
	no_write_when_full: assert property (@(posedge clk) disable iff (!reset_n)
		wr_en |-> fifo_count != fill_t'(fifo_depth));

endmodule

`default_nettype wire

/* sources.f */
imgproc_pkg.sv
stream_reg.sv
hsv_convert.sv
colour_classifier.sv
frame_tracker.sv
msg_writer.sv
msg_fifo.sv
mm_regs.sv
eee_imgproc.sv
tb_imgproc.sv

/* stream_reg.sv */
`default_nettype none

module stream_reg (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                in_valid,
	output logic                in_ready,
	input  imgproc_pkg::beat_t  in_beat,
	output logic                out_valid,
	input  logic                out_ready,
	output imgproc_pkg::beat_t  out_beat
);
	import imgproc_pkg::*;

	logic full;   // Holding a beat
	beat_t data;

	// Take a new beat when empty or when the held one leaves now
	assign in_ready  = ~full | out_ready;
	assign out_valid = full;
	assign out_beat  = data;

	always_ff @(posedge clk) begin
		if (!reset_n)
			full <= 1'b0;
		else if (in_ready)
			full <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			data <= in_beat;
	end

	// A stalled beat is held until the consumer takes it
	held_beat_stable: assert property (@(posedge clk) disable iff (!reset_n)
		out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

`default_nettype wire

/* tb_imgproc.sv */
`default_nettype none

module tb_imgproc;
	import imgproc_pkg::*;

	localparam int IMG_W = 16;
	localparam int IMG_H = 8;
	localparam int MAX_FR = 8;
	localparam int BURST = 6;

	logic clk = 1'b0;
	logic reset_n;
	logic s_chipselect;
	logic s_read;
	logic s_write;
	msg_word_t s_readdata;
	msg_word_t s_writedata;
	logic [2:0] s_address;
	rgb_t sink_data;
	logic sink_valid;
	logic sink_ready;
	logic sink_sop;
	logic sink_eop;
	rgb_t source_data;
	logic source_valid;
	logic source_ready;
	logic source_sop;
	logic source_eop;
	logic mode;

	integer seed = 32'h202d6ca9;
	int err_cnt = 0;
	int nfr;
	int wd_cycles;
	logic loaded = 1'b0;

	// Frame records from the golden file
	rgb_t fr_bg [MAX_FR];
	int fr_mode [MAX_FR];
	int fr_nrect [MAX_FR];
	int fr_act [MAX_FR];                 // Zero reads the burst and one flushes it
	rgb_t rc_col [MAX_FR][NUM_CLASSES];
	rgb_t rc_hl [MAX_FR][NUM_CLASSES];
	int rc_l [MAX_FR][NUM_CLASSES];
	int rc_r [MAX_FR][NUM_CLASSES];
	int rc_t [MAX_FR][NUM_CLASSES];
	int rc_b [MAX_FR][NUM_CLASSES];
	msg_word_t gold_msg [MAX_FR][BURST];

	coord_t edge_l [NUM_CLASSES];        // Box edges of the previous frame
	coord_t edge_r [NUM_CLASSES];
	beat_t exp_q [$];
	bit full_q [$];                      // Pixel value is checked too

	eee_imgproc #(.image_w(IMG_W), .image_h(IMG_H), .horizon_row(2), .run_len(3),
		.msg_interval(1), .fifo_depth(256)) dut (
		.clk, .reset_n, .s_chipselect, .s_read, .s_write, .s_readdata, .s_writedata,
		.s_address, .sink_data, .sink_valid, .sink_ready, .sink_sop, .sink_eop,
		.source_data, .source_valid, .source_ready, .source_sop, .source_eop, .mode);

	always #5 clk = ~clk;

	// Random back-pressure on the source side
	initial begin
		forever begin
			@(posedge clk);
			#1;
			source_ready = ($random(seed) & 3) != 0;
		end
	end

	initial begin
		wait (loaded);
		repeat (wd_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", wd_cycles);
		stop_on_error();
	end

	task automatic stop_on_error();
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	task automatic check_beat(input string what, input beat_t got, input beat_t exp,
		input bit full);
		logic bad;
		bad = full ? (got !== exp) : (got.sop !== exp.sop || got.eop !== exp.eop);
		if (bad) begin
			err_cnt++;
			$display("** Error: %s got %h expected %h", what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_word(input string what, input msg_word_t got, input msg_word_t exp);
		if (got !== exp) begin
			err_cnt++;
			$display("** Error: %s got %h expected %h", what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_count(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("** Error: %s got %h expected %h", what, got, exp);
			stop_on_error();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Golden file reader
	task automatic load_golden();
		int fd;
		int code;
		int c;
		int k;
		logic [7:0] ch;
		fd = $fopen("imgproc_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden file imgproc_golden.txt");
			stop_on_error();
		end
		nfr = 0;
		k = 0;
		while ($fscanf(fd, " %c", ch) == 1) begin
			code = 0;
			case (ch)
				"#": begin
					c = $fgetc(fd);   // Skip the rest of a comment line
					while (c != "\n" && c != -1)
						c = $fgetc(fd);
					code = -1;
				end
				"F": begin
					code = $fscanf(fd, "%h %d %d %d", fr_bg[nfr], fr_mode[nfr],
						fr_nrect[nfr], fr_act[nfr]) - 4;
					k = 0;
				end
				"R": begin
					code = $fscanf(fd, "%h %d %d %d %d %h", rc_col[nfr][k], rc_l[nfr][k],
						rc_r[nfr][k], rc_t[nfr][k], rc_b[nfr][k], rc_hl[nfr][k]) - 6;
					k++;
				end
				"M": begin
					code = $fscanf(fd, "%h %h %h %h %h %h", gold_msg[nfr][0], gold_msg[nfr][1],
						gold_msg[nfr][2], gold_msg[nfr][3], gold_msg[nfr][4],
						gold_msg[nfr][5]) - 6;
					nfr++;
				end
				default: code = 1;
			endcase
			if (code > 0 || code < -1 || nfr > MAX_FR) begin
				$display("Malformed record in the golden file near frame %0d", nfr);
				stop_on_error();
			end
		end
		$fclose(fd);
	endtask

	function automatic int rect_at(input int f, input int x, input int y);
		int hit;
		hit = -1;
		for (int k = fr_nrect[f] - 1; k >= 0; k--) begin   // First listed wins
			if (x >= rc_l[f][k] && x <= rc_r[f][k] && y >= rc_t[f][k] && y <= rc_b[f][k])
				hit = k;
		end
		return hit;
	endfunction

	function automatic logic on_edge(input int x);
		logic hit;
		hit = 1'b0;
		for (int i = 0; i < NUM_CLASSES; i++)
			hit |= (coord_t'(x) == edge_l[i]) || (coord_t'(x) == edge_r[i]);
		return hit;
	endfunction

	// Left edge min - pad equals right minus width
	task automatic update_edges(input int f);
		msg_word_t w;
		for (int i = 0; i < NUM_CLASSES; i++) begin
			w = gold_msg[f][2 * i + 1];
			edge_r[i] = w[26:16];
			edge_l[i] = w[26:16] - w[10:0];
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stream and slave bus drivers
	task automatic send_beat(input beat_t b);
		logic accepted;
		{sink_data, sink_sop, sink_eop} = b;
		sink_valid = 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = sink_ready;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic send_frame(input int f);
		beat_t b;
		beat_t exp;
		bit full;
		int k;
		b = {24'h000000, 1'b1, 1'b0};   // Video header with type nibble 0
		exp_q.push_back(b);
		full_q.push_back(1'b1);
		send_beat(b);
		for (int y = 0; y < IMG_H; y++) begin
			for (int x = 0; x < IMG_W; x++) begin
				k = rect_at(f, x, y);
				b.pix = (k >= 0) ? rc_col[f][k] : fr_bg[f];
				b.sop = 1'b0;
				b.eop = (x == IMG_W - 1) && (y == IMG_H - 1);
				exp = b;
				full = 1'b1;
				if (fr_mode[f] != 0) begin
					if (k >= 0 && !on_edge(x))
						exp.pix = rc_hl[f][k];
					else
						full = 1'b0;   // Only the flags are known for grey or overlay
				end
				exp_q.push_back(exp);
				full_q.push_back(full);
				send_beat(b);
			end
		end
		sink_valid = 1'b0;
	endtask

	task automatic collect_beats(input int n);
		beat_t got;
		beat_t exp;
		bit full;
		int got_n;
		got_n = 0;
		while (got_n < n) begin
			@(negedge clk);
			if (source_valid && source_ready) begin
				got = {source_data, source_sop, source_eop};
				if (exp_q.size() == 0) begin
					$display("An output beat arrived with no input beat pending");
					stop_on_error();
				end
				exp = exp_q.pop_front();
				full = full_q.pop_front();
				check_beat($sformatf("source beat %0d (source_data, sop, eop)", got_n),
					got, exp, full);
				got_n++;
			end
		end
	endtask

	task automatic mm_read(input logic [2:0] addr, output msg_word_t data);
		@(posedge clk);
		#1;
		s_chipselect = 1'b1;
		s_read = 1'b1;
		s_address = addr;
		@(posedge clk);
		#1;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		data = s_readdata;   // Registered on the edge just passed
	endtask

	task automatic mm_write(input logic [2:0] addr, input msg_word_t data);
		@(posedge clk);
		#1;
		s_chipselect = 1'b1;
		s_write = 1'b1;
		s_address = addr;
		s_writedata = data;
		@(posedge clk);
		#1;
		s_chipselect = 1'b0;
		s_write = 1'b0;
	endtask

	task automatic read_status(input string what, input int level);
		msg_word_t w;
		mm_read(ADDR_STATUS, w);
		check_count(what, w[15:8], 8'(level));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	initial begin
		msg_word_t w;
		int level;
		reset_n = 1'b0;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		s_write = 1'b0;
		s_writedata = '0;
		s_address = '0;
		sink_data = '0;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		source_ready = 1'b0;
		mode = 1'b0;
		load_golden();
		wd_cycles = nfr * (IMG_W * IMG_H + 1) * 4 + 2000;
		loaded = 1'b1;
		for (int i = 0; i < NUM_CLASSES; i++) begin
			edge_l[i] = '1;   // No box before the first frame
			edge_r[i] = '1;
		end
		repeat (4) @(posedge clk);
		#1;
		reset_n = 1'b1;

		mm_read(ADDR_ID, w);
		check_word("s_readdata at ADDR_ID", w, 32'h1234EEE2);
		level = 0;

		for (int f = 0; f < nfr; f++) begin
			mode = (fr_mode[f] != 0);
			fork
				send_frame(f);
				collect_beats(IMG_W * IMG_H + 1);
			join
			repeat (8) @(posedge clk);   // Burst is done six cycles after frame end
			#1;
			level += BURST;
			read_status($sformatf("status count after frame %0d", f), level);
			if (fr_act[f] != 0) begin
				mm_write(ADDR_STATUS, msg_word_t'(1) << FLUSH_BIT);
				level = 0;
				read_status($sformatf("status count after flush, frame %0d", f), level);
			end else begin
				for (int k = 0; k < BURST; k++) begin
					mm_read(ADDR_MSG, w);
					check_word($sformatf("s_readdata message %0d of frame %0d", k, f),
						w, gold_msg[f][k]);
					level--;
					read_status($sformatf("status count after read %0d", k), level);
				end
			end
			update_edges(f);
		end

		if (err_cnt == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			stop_on_error();
		end
	end

endmodule

`default_nettype wire
